//--- src/vtp_pkg.sv
// VTP failure routing package with widths, CSR map, request and failure-count types
`default_nettype none

package vtp_pkg;

    // ====================
    // Widths
    // ====================

    // Virtual and physical addresses share one width
    localparam int ADDR_WIDTH = 64;
    localparam int DATA_WIDTH = 64;

    // 4 KB pages
    localparam int PAGE_BITS = 12;

    // MMIO addresses arrive as qword indexes
    localparam int CSR_ADDR_WIDTH = 6;

    // ====================
    // CSR map
    // ====================

    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_TEST_ID_LO = 6'd0;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_TEST_ID_HI = 6'd1;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_CONFIG = 6'd2;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_RD_FAIL_VA = 6'd3;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_WR_FAIL_VA = 6'd4;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_FAIL_CNT = 6'd7;
    // First page table entry, one qword per entry from here on
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_PT_BASE = 6'd16;

    // Software matches this value before it trusts the rest of the map
    localparam logic [127:0] TEST_ID = 128'h7a3e90c2_5d14_4f8b_b6a1_2e9c0f47d385;

    // ====================
    // Types
    // ====================

    // One memory request as seen by the engine and by the host port
    typedef struct packed {
        logic write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } mem_req_t;

    // Layout of the failure count CSR, reads in the low field
    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [15:0] rsvd_lo;
        logic [15:0] wr_cnt;
        logic [15:0] rd_cnt;
    } fail_cnt_t;

    // The same CSR seen as a plain word by the read mux
    typedef union packed {
        logic [DATA_WIDTH-1:0] word;
        fail_cnt_t fields;
    } fail_cnt_word_u;

endpackage

`default_nettype wire

//--- src/page_xlate.sv
// Direct-mapped page table that translates requests and splits them into host or failure paths
`timescale 1ns/100ps
`default_nettype none

module page_xlate
    import vtp_pkg::*;
#(
    parameter int PT_ENTRIES = 16
)
(
    input wire logic clk,
    input wire logic rst_n,

    input wire logic req_valid,
    input wire mem_req_t req,

    input wire logic pt_wr_valid,
    input wire logic [$clog2(PT_ENTRIES)-1:0] pt_wr_index,
    input wire logic [DATA_WIDTH-1:0] pt_wr_entry,
    input wire logic [$clog2(PT_ENTRIES)-1:0] pt_rd_index,

    output logic host_valid,
    output mem_req_t host_req,

    output logic fail_valid,
    output logic fail_write,
    output logic [ADDR_WIDTH-1:0] fail_addr,

    output logic [DATA_WIDTH-1:0] pt_rd_entry
);

    localparam int IDX_W = $clog2(PT_ENTRIES);
    // Address bits from here up must be zero for a hit
    localparam int TAG_LO = PAGE_BITS + IDX_W;
    localparam int PPN_W = ADDR_WIDTH - PAGE_BITS;

    // Bit 63 marks a valid entry, the low bits hold the physical page number
    logic [DATA_WIDTH-1:0] pt_q [PT_ENTRIES];

    logic [IDX_W-1:0] lkup_index;
    logic [DATA_WIDTH-1:0] lkup_entry;
    logic lkup_fail;

    // ====================
    // Page table storage
    // ====================

    // The lookup reads the old entry on the write cycle, so a new entry
    // is used by requests from the following cycle on
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < PT_ENTRIES; i++)
            begin
                pt_q[i] <= '0;
            end
        end
        else if (pt_wr_valid)
        begin
            pt_q[pt_wr_index] <= pt_wr_entry;
        end
    end

    // Software read-back path, no latency of its own
    assign pt_rd_entry = pt_q[pt_rd_index];

    // ====================
    // Lookup and routing
    // ====================

    assign lkup_index = req.addr[PAGE_BITS +: IDX_W];
    assign lkup_entry = pt_q[lkup_index];

    // A miss is an invalid entry or an address beyond the mapped range
    assign lkup_fail = !lkup_entry[DATA_WIDTH-1] || (|req.addr[ADDR_WIDTH-1:TAG_LO]);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            host_valid <= 1'b0;
            fail_valid <= 1'b0;
        end
        else
        begin
            host_valid <= req_valid && !lkup_fail;
            fail_valid <= req_valid && lkup_fail;
        end
    end

    // Both paths load from the same request, the valids pick the winner
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            host_req.write <= req.write;
            host_req.addr <= {lkup_entry[PPN_W-1:0], req.addr[PAGE_BITS-1:0]};
            host_req.data <= req.data;
            // Failures keep the original virtual address
            fail_write <= req.write;
            fail_addr <= req.addr;
        end
    end

    // The table index and the range check both need a fully known address
    a_req_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> !$isunknown(req.addr));

endmodule

`default_nettype wire

//--- src/fail_stats.sv
// Failure statistics with last failing address and saturating counts per direction
`timescale 1ns/100ps
`default_nettype none

module fail_stats
    import vtp_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,

    input wire logic fail_valid,
    input wire logic fail_write,
    input wire logic [ADDR_WIDTH-1:0] fail_addr,

    output logic [ADDR_WIDTH-1:0] rd_fail_va,
    output logic [ADDR_WIDTH-1:0] wr_fail_va,
    output fail_cnt_word_u fail_cnt
);

    fail_cnt_t cnt_q;

    // Software polls these, so they must read as zero until a failure occurs
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_fail_va <= '0;
            wr_fail_va <= '0;
            cnt_q <= '0;
        end
        else if (fail_valid)
        begin
            if (fail_write)
            begin
                wr_fail_va <= fail_addr;
                // Stick at all ones rather than wrap
                if (cnt_q.wr_cnt != '1)
                begin
                    cnt_q.wr_cnt <= cnt_q.wr_cnt + 16'd1;
                end
            end
            else
            begin
                rd_fail_va <= fail_addr;
                if (cnt_q.rd_cnt != '1)
                begin
                    cnt_q.rd_cnt <= cnt_q.rd_cnt + 16'd1;
                end
            end
        end
    end

    // The CSR manager sees this as one word
    assign fail_cnt.fields = cnt_q;

    // The direction picks which address and count move on a failure
    a_dir_known: assert property (@(posedge clk) disable iff (!rst_n)
        fail_valid |-> !$isunknown(fail_write));

endmodule

`default_nettype wire

//--- src/csr_mgr.sv
// MMIO CSR manager with global read mux, page table load port and registered read response
`timescale 1ns/100ps
`default_nettype none

module csr_mgr
    import vtp_pkg::*;
#(
    parameter int PT_ENTRIES = 16
)
(
    input wire logic clk,
    input wire logic rst_n,

    // MMIO request side
    input wire logic mmio_wr,
    input wire logic mmio_rd,
    input wire logic [CSR_ADDR_WIDTH-1:0] mmio_addr,
    input wire logic [DATA_WIDTH-1:0] mmio_wdata,
    input wire logic [8:0] mmio_tid,

    // Statistics from the failure path
    input wire logic [ADDR_WIDTH-1:0] rd_fail_va,
    input wire logic [ADDR_WIDTH-1:0] wr_fail_va,
    input wire fail_cnt_word_u fail_cnt,

    // Page table access
    input wire logic [DATA_WIDTH-1:0] pt_rd_entry,
    output logic pt_wr_valid,
    output logic [$clog2(PT_ENTRIES)-1:0] pt_wr_index,
    output logic [DATA_WIDTH-1:0] pt_wr_entry,
    output logic [$clog2(PT_ENTRIES)-1:0] pt_rd_index,

    // MMIO read response
    output logic mmio_rd_valid,
    output logic [DATA_WIDTH-1:0] mmio_rdata,
    output logic [8:0] mmio_rd_tid
);

    localparam int IDX_W = $clog2(PT_ENTRIES);

    logic [CSR_ADDR_WIDTH-1:0] pt_off;
    logic in_pt;
    logic [DATA_WIDTH-1:0] rd_data;

    // ====================
    // Page table window
    // ====================

    // Offset into the table, wraps high for indexes below the base
    assign pt_off = mmio_addr - CSR_PT_BASE;
    assign in_pt = (mmio_addr >= CSR_PT_BASE) && (int'(pt_off) < PT_ENTRIES);

    // Writes go straight to the table so they land at the end of this cycle
    assign pt_wr_valid = mmio_wr && in_pt;
    assign pt_wr_index = pt_off[IDX_W-1:0];
    assign pt_wr_entry = mmio_wdata;

    // The table answers combinationally and the response register samples it
    assign pt_rd_index = pt_off[IDX_W-1:0];

    // ====================
    // Read mux
    // ====================

    always_comb
    begin
        rd_data = '0;
        case (mmio_addr)
            CSR_TEST_ID_LO: rd_data = TEST_ID[63:0];
            CSR_TEST_ID_HI: rd_data = TEST_ID[127:64];
            // Table size above page size so software can size its mappings
            CSR_CONFIG: rd_data = {48'd0, 8'(PT_ENTRIES), 8'(PAGE_BITS)};
            CSR_RD_FAIL_VA: rd_data = rd_fail_va;
            CSR_WR_FAIL_VA: rd_data = wr_fail_va;
            CSR_FAIL_CNT: rd_data = fail_cnt.word;
            default: rd_data = '0;
        endcase

        if (in_pt)
        begin
            rd_data = pt_rd_entry;
        end
    end

    // ====================
    // Read response
    // ====================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mmio_rd_valid <= 1'b0;
        end
        else
        begin
            mmio_rd_valid <= mmio_rd;
        end
    end

    // Data and tid only move on a read so the last response stays visible
    always_ff @(posedge clk)
    begin
        if (mmio_rd)
        begin
            mmio_rdata <= rd_data;
            mmio_rd_tid <= mmio_tid;
        end
    end

    // The host never issues a read and a write in the same cycle
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(mmio_rd && mmio_wr));

endmodule

`default_nettype wire

//--- src/vtp_afu.sv
// Top level of the translation core that wires lookup, failure statistics and CSRs
`timescale 1ns/100ps
`default_nettype none

module vtp_afu
    import vtp_pkg::*;
#(
    // Power of two, 32 or fewer, so the table fits below CSR index 64
    parameter int PT_ENTRIES = 16
)
(
    input wire logic clk,
    input wire logic rst_n,

    // Engine side, virtual addresses
    input wire logic req_valid,
    input wire mem_req_t req,

    // Host side, physical addresses
    output logic host_valid,
    output mem_req_t host_req,

    // MMIO
    input wire logic mmio_wr,
    input wire logic mmio_rd,
    input wire logic [CSR_ADDR_WIDTH-1:0] mmio_addr,
    input wire logic [DATA_WIDTH-1:0] mmio_wdata,
    input wire logic [8:0] mmio_tid,
    output logic mmio_rd_valid,
    output logic [DATA_WIDTH-1:0] mmio_rdata,
    output logic [8:0] mmio_rd_tid
);

    localparam int IDX_W = $clog2(PT_ENTRIES);

    logic fail_valid;
    logic fail_write;
    logic [ADDR_WIDTH-1:0] fail_addr;

    logic [ADDR_WIDTH-1:0] rd_fail_va;
    logic [ADDR_WIDTH-1:0] wr_fail_va;
    fail_cnt_word_u fail_cnt;

    logic pt_wr_valid;
    logic [IDX_W-1:0] pt_wr_index;
    logic [DATA_WIDTH-1:0] pt_wr_entry;
    logic [IDX_W-1:0] pt_rd_index;
    logic [DATA_WIDTH-1:0] pt_rd_entry;

    // ====================
    // Translation
    // ====================

    page_xlate #(
        .PT_ENTRIES(PT_ENTRIES)
    ) xlate_i (
        .clk, .rst_n,
        .req_valid, .req,
        .pt_wr_valid, .pt_wr_index, .pt_wr_entry, .pt_rd_index,
        .host_valid, .host_req,
        .fail_valid, .fail_write, .fail_addr,
        .pt_rd_entry
    );

    // Failed requests end here, they are counted and dropped
    fail_stats stats_i (
        .clk, .rst_n,
        .fail_valid, .fail_write, .fail_addr,
        .rd_fail_va, .wr_fail_va, .fail_cnt
    );

    // ====================
    // CSRs
    // ====================

    csr_mgr #(
        .PT_ENTRIES(PT_ENTRIES)
    ) csr_i (
        .clk, .rst_n,
        .mmio_wr, .mmio_rd, .mmio_addr, .mmio_wdata, .mmio_tid,
        .rd_fail_va, .wr_fail_va, .fail_cnt,
        .pt_rd_entry,
        .pt_wr_valid, .pt_wr_index, .pt_wr_entry, .pt_rd_index,
        .mmio_rd_valid, .mmio_rdata, .mmio_rd_tid
    );

endmodule

`default_nettype wire

//--- verification/exp_types.svh
// Expected response record shared by the testbench and the response checker
`ifndef EXP_TYPES_SVH
`define EXP_TYPES_SVH

// What the checker looks for one cycle after a step is issued
localparam logic [1:0] K_QUIET = 2'd0;
localparam logic [1:0] K_HOST = 2'd1;
localparam logic [1:0] K_DROP = 2'd2;
localparam logic [1:0] K_READ = 2'd3;

// Host requests use write, addr and data, CSR reads use data and tid
typedef struct packed {
    logic [1:0] kind;
    logic write;
    logic [63:0] addr;
    logic [63:0] data;
    logic [8:0] tid;
} exp_t;

`endif

//--- verification/vtp_checker.sv
// Response checker that compares host and MMIO outputs with the expected record
`timescale 1ns/100ps
`default_nettype none
`include "exp_types.svh"

module vtp_checker
    import vtp_pkg::*;
(
    input wire logic clk,
    input wire logic exp_valid,
    input wire exp_t exp,
    input wire logic host_valid,
    input wire mem_req_t host_req,
    input wire logic mmio_rd_valid,
    input wire logic [DATA_WIDTH-1:0] mmio_rdata,
    input wire logic [8:0] mmio_rd_tid,
    output int tests_done,
    output int errors
);

    logic pend_valid;
    exp_t pend;

    initial
    begin
        tests_done = 0;
        errors = 0;
        pend_valid = 1'b0;
    end

    // The DUT samples the step on this edge, so the expectation is taken here too
    always @(posedge clk)
    begin
        pend_valid <= exp_valid;
        pend <= exp;
    end

    // Registered outputs have settled by the falling edge after the sampling edge
    always @(negedge clk)
    begin
        if (pend_valid)
        begin
            case (pend.kind)
                K_HOST:
                begin
                    if (!host_valid)
                    begin
                        $display("Test %0d failed, no host request came out", tests_done);
                        errors++;
                    end
                    else if (host_req.write !== pend.write || host_req.addr !== pend.addr ||
                             host_req.data !== pend.data)
                    begin
                        $display(
                            "ERROR %0t: test %0d host w=%b a=%h d=%h, expected w=%b a=%h d=%h",
                            $time, tests_done, host_req.write, host_req.addr, host_req.data,
                            pend.write, pend.addr, pend.data);
                        errors++;
                    end
                    else
                    begin
                        $display("Test %0d ok, host request at %h", tests_done, host_req.addr);
                    end
                end
                K_DROP:
                begin
                    // A failed translation must never reach the host port
                    if (host_valid)
                    begin
                        $display("ERROR %0t: test %0d dropped request reached host at %h",
                                 $time, tests_done, host_req.addr);
                        errors++;
                    end
                    else
                    begin
                        $display("Test %0d ok, request dropped", tests_done);
                    end
                end
                K_READ:
                begin
                    if (!mmio_rd_valid)
                    begin
                        $display("Test %0d failed, no CSR read response came back", tests_done);
                        errors++;
                    end
                    else if (mmio_rdata !== pend.data || mmio_rd_tid !== pend.tid)
                    begin
                        $display("ERROR %0t: test %0d read %h tid %h, expected %h tid %h",
                                 $time, tests_done, mmio_rdata, mmio_rd_tid, pend.data, pend.tid);
                        errors++;
                    end
                    else
                    begin
                        $display("Test %0d ok, CSR read %h", tests_done, mmio_rdata);
                    end
                end
                default:
                begin
                    // Page table loads give no response on either port
                    if (host_valid || mmio_rd_valid)
                    begin
                        $display("ERROR %0t: test %0d unexpected output host=%b rd=%b",
                                 $time, tests_done, host_valid, mmio_rd_valid);
                        errors++;
                    end
                    else
                    begin
                        $display("Test %0d ok, no response", tests_done);
                    end
                end
            endcase
            tests_done++;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_vtp_afu.sv
// Testbench for the translation core that applies a stimulus table to the DUT
`timescale 1ns/100ps
`default_nettype none
`include "exp_types.svh"

module tb_vtp_afu
    import vtp_pkg::*;
();

    localparam int PT_ENTRIES = 16;
    // Cycles a single wait may take before the run is abandoned
    localparam int WAIT_LIMIT = 20;

    localparam logic [1:0] OP_PT_WR = 2'd0;
    localparam logic [1:0] OP_REQ = 2'd1;
    localparam logic [1:0] OP_RD = 2'd2;

    // One table row, exp_val is the physical address or the CSR read data
    typedef struct packed {
        logic [1:0] op;
        logic write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [8:0] tid;
        logic [1:0] kind;
        logic [DATA_WIDTH-1:0] exp_val;
        logic sync;
    } step_t;

    logic clk;
    logic rst_n;
    logic req_valid;
    mem_req_t req;
    logic host_valid;
    mem_req_t host_req;
    logic mmio_wr;
    logic mmio_rd;
    logic [CSR_ADDR_WIDTH-1:0] mmio_addr;
    logic [DATA_WIDTH-1:0] mmio_wdata;
    logic [8:0] mmio_tid;
    logic mmio_rd_valid;
    logic [DATA_WIDTH-1:0] mmio_rdata;
    logic [8:0] mmio_rd_tid;

    logic exp_valid;
    exp_t exp;
    int tests_done;
    int errors;
    integer seed;
    bit timed_out;
    step_t steps[$];

    vtp_afu #(
        .PT_ENTRIES(PT_ENTRIES)
    ) dut_i (
        .clk, .rst_n,
        .req_valid, .req,
        .host_valid, .host_req,
        .mmio_wr, .mmio_rd, .mmio_addr, .mmio_wdata, .mmio_tid,
        .mmio_rd_valid, .mmio_rdata, .mmio_rd_tid
    );

    vtp_checker chk_i (
        .clk, .exp_valid, .exp,
        .host_valid, .host_req,
        .mmio_rd_valid, .mmio_rdata, .mmio_rd_tid,
        .tests_done, .errors
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // Table rows
    // ====================

    function automatic step_t csr_read(input logic [5:0] index, input logic [8:0] tid,
                                       input logic [63:0] value, input logic sync);
        step_t s;
        s = '0;
        s.op = OP_RD;
        s.addr = index;
        s.tid = tid;
        s.kind = K_READ;
        s.exp_val = value;
        s.sync = sync;
        return s;
    endfunction

    function automatic step_t pt_load(input int index, input logic [63:0] entry);
        step_t s;
        s = '0;
        s.op = OP_PT_WR;
        s.addr = CSR_PT_BASE + index;
        s.data = entry;
        s.kind = K_QUIET;
        return s;
    endfunction

    function automatic step_t mem_access(input logic write, input logic [63:0] vaddr,
                                         input logic [1:0] kind, input logic [63:0] paddr,
                                         input logic sync);
        step_t s;
        s = '0;
        s.op = OP_REQ;
        s.write = write;
        s.addr = vaddr;
        s.kind = kind;
        s.exp_val = paddr;
        s.sync = sync;
        return s;
    endfunction

    // Physical addresses are the entry's page number joined with the 12-bit offset
    task automatic build_table();
        steps.push_back(csr_read(CSR_TEST_ID_LO, 9'h001, TEST_ID[63:0], 1'b0));
        steps.push_back(csr_read(CSR_TEST_ID_HI, 9'h002, TEST_ID[127:64], 1'b0));
        steps.push_back(csr_read(CSR_CONFIG, 9'h003, 64'h100c, 1'b0));
        steps.push_back(csr_read(CSR_RD_FAIL_VA, 9'h004, 64'h0, 1'b0));
        steps.push_back(csr_read(CSR_WR_FAIL_VA, 9'h005, 64'h0, 1'b0));
        steps.push_back(csr_read(CSR_FAIL_CNT, 9'h006, 64'h0, 1'b1));
        steps.push_back(pt_load(3, 64'h8000_0000_0001_2345));
        steps.push_back(pt_load(9, 64'h8000_0000_000a_bcde));
        // Back-to-back requests, the first one uses the entry loaded just before
        steps.push_back(mem_access(1'b1, 64'h9008, K_HOST, 64'habcd_e008, 1'b0));
        steps.push_back(mem_access(1'b0, 64'h37f0, K_HOST, 64'h1234_57f0, 1'b0));
        steps.push_back(mem_access(1'b1, 64'h3000, K_HOST, 64'h1234_5000, 1'b1));
        // Entry 5 was never loaded
        steps.push_back(mem_access(1'b0, 64'h5040, K_DROP, 64'h0, 1'b1));
        steps.push_back(csr_read(CSR_RD_FAIL_VA, 9'h1a5, 64'h5040, 1'b0));
        steps.push_back(csr_read(CSR_FAIL_CNT, 9'h0f0, 64'h1, 1'b1));
        // Bit 16 lies above the index of a 16-entry table
        steps.push_back(mem_access(1'b1, 64'h1_3008, K_DROP, 64'h0, 1'b1));
        steps.push_back(csr_read(CSR_WR_FAIL_VA, 9'h07e, 64'h1_3008, 1'b0));
        steps.push_back(csr_read(CSR_FAIL_CNT, 9'h100, 64'h1_0001, 1'b0));
        steps.push_back(csr_read(CSR_PT_BASE + 3, 9'h033, 64'h8000_0000_0001_2345, 1'b0));
        steps.push_back(csr_read(CSR_PT_BASE + 9, 9'h099, 64'h8000_0000_000a_bcde, 1'b0));
        steps.push_back(csr_read(CSR_PT_BASE + 4, 9'h044, 64'h0, 1'b0));
        steps.push_back(csr_read(6'd5, 9'h055, 64'h0, 1'b0));
        steps.push_back(csr_read(6'd63, 9'h1ff, 64'h0, 1'b1));
    endtask

    // ====================
    // Driving
    // ====================

    task automatic apply_step(input step_t s);
        logic [DATA_WIDTH-1:0] payload;
        payload = {$random(seed), $random(seed)};
        req_valid = (s.op == OP_REQ);
        req.write = s.write;
        req.addr = s.addr;
        req.data = payload;
        mmio_wr = (s.op == OP_PT_WR);
        mmio_rd = (s.op == OP_RD);
        mmio_addr = s.addr[CSR_ADDR_WIDTH-1:0];
        mmio_wdata = s.data;
        mmio_tid = s.tid;
        exp_valid = 1'b1;
        exp.kind = s.kind;
        exp.write = s.write;
        exp.addr = s.exp_val;
        // Write data passes through translation unchanged
        exp.data = (s.op == OP_RD) ? s.exp_val : payload;
        exp.tid = s.tid;
    endtask

    task automatic drive_idle();
        req_valid = 1'b0;
        mmio_wr = 1'b0;
        mmio_rd = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic wait_checked(input int count, output bit ok);
        int cycles;
        cycles = 0;
        while (tests_done < count && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        ok = (tests_done >= count);
    endtask

    initial
    begin
        bit ok;
        seed = 32'h512e73d8;
        timed_out = 1'b0;
        rst_n = 1'b0;
        req = '0;
        mmio_addr = '0;
        mmio_wdata = '0;
        mmio_tid = '0;
        exp = '0;
        drive_idle();
        build_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        foreach (steps[i])
        begin
            if (!timed_out)
            begin
                @(negedge clk);
                apply_step(steps[i]);
                // Synced rows let the statistics settle before the next row
                if (steps[i].sync)
                begin
                    @(negedge clk);
                    drive_idle();
                    wait_checked(i + 1, ok);
                    if (!ok)
                    begin
                        $display("Timed out waiting for the result of test %0d", i);
                        timed_out = 1'b1;
                    end
                end
            end
        end

        if (!timed_out)
        begin
            @(negedge clk);
            drive_idle();
            wait_checked(steps.size(), ok);
            if (!ok)
            begin
                $display("Timed out waiting for the last results");
                timed_out = 1'b1;
            end
        end

        $display("%0d of %0d tests checked, %0d passed, %0d failed", tests_done, steps.size(),
                 tests_done - errors, errors);
        if (!timed_out && errors == 0 && tests_done == steps.size())
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vtp_fail_route.f
+incdir+verification
src/vtp_pkg.sv
src/page_xlate.sv
src/fail_stats.sv
src/csr_mgr.sv
src/vtp_afu.sv
verification/vtp_checker.sv
verification/tb_vtp_afu.sv
